/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
PASS_TEXT := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* list.f */
+incdir+testbench
source/cpu_pkg.sv
source/instr_if.sv
source/storage_bank.sv
source/cpu_alu.sv
source/cpu_sequencer.sv
source/cpu_core.sv
testbench/tb_cpu.sv

/* source/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu
(
    instr_if.datapath      instr,
    input  cpu_pkg::word_t operand_a,
    input  cpu_pkg::word_t operand_b,
    output cpu_pkg::word_t result,
    output logic           flag
);

    localparam int PAD_WIDTH = cpu_pkg::WORD_WIDTH - cpu_pkg::VALUE_WIDTH;

    logic [cpu_pkg::WORD_WIDTH:0] sum;
    logic                         a_below_b;

    // carry out of the adder is the top bit
    assign sum       = {1'b0, operand_a} + {1'b0, operand_b};
    assign a_below_b = operand_a < operand_b;

    always_comb
    begin
        result = '0;
        flag   = 1'b0;
        case (instr.opcode)
            cpu_pkg::OP_ADD:
            begin
                result = sum[cpu_pkg::WORD_WIDTH-1:0];
                flag   = sum[cpu_pkg::WORD_WIDTH];
            end
            cpu_pkg::OP_SUB:
            begin
                result = operand_a - operand_b;
                // borrow
                flag   = a_below_b;
            end
            cpu_pkg::OP_AND:
            begin
                result = operand_a & operand_b;
                flag   = result == '0;
            end
            cpu_pkg::OP_OR:
            begin
                result = operand_a | operand_b;
                flag   = result == '0;
            end
            cpu_pkg::OP_XOR:
            begin
                result = operand_a ^ operand_b;
                flag   = result == '0;
            end
            cpu_pkg::OP_LDI:
            begin
                // highlow set keeps the low half of ra
                if (instr.highlow)
                begin
                    result = {instr.value, operand_a[cpu_pkg::VALUE_WIDTH-1:0]};
                end
                else
                begin
                    result = {{PAD_WIDTH{1'b0}}, instr.value};
                end
                flag = result == '0;
            end
            cpu_pkg::OP_CMPLT:
            begin
                result = {{(cpu_pkg::WORD_WIDTH-1){1'b0}}, a_below_b};
                flag   = a_below_b;
            end
            default:
            begin
                // nop, store, branches and unassigned codes have no register result
                result = '0;
                flag   = 1'b0;
            end
        endcase
    end

endmodule

/* source/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core
(
    input  logic           clock,
    input  logic           arst_n,
    input  logic           step,
    input  cpu_pkg::word_t data,
    output cpu_pkg::word_t datao,
    output cpu_pkg::word_t address,
    output logic           rw
);

    cpu_pkg::word_t reg_a_value;
    cpu_pkg::word_t reg_b_value;
    cpu_pkg::word_t alu_result;
    logic           alu_flag;
    logic           flag_a_value;
    logic           reg_write;

    instr_if instr_i ();

    cpu_sequencer sequencer_i
    (
        .clock         (clock),
        .arst_n        (arst_n),
        .step          (step),
        .data          (data),
        .store_address (reg_b_value),
        .branch_flag   (flag_a_value),
        .instr         (instr_i),
        .reg_write     (reg_write),
        .address       (address),
        .rw            (rw)
    );

    cpu_alu alu_i
    (
        .instr     (instr_i),
        .operand_a (reg_a_value),
        .operand_b (reg_b_value),
        .result    (alu_result),
        .flag      (alu_flag)
    );

    storage_bank #(.entry_t(cpu_pkg::word_t)) reg_bank_i
    (
        .clock        (clock),
        .arst_n       (arst_n),
        .write_enable (reg_write),
        .write_index  (instr_i.rd),
        .write_data   (alu_result),
        .read_index_a (instr_i.ra),
        .read_index_b (instr_i.rb),
        .read_a       (reg_a_value),
        .read_b       (reg_b_value)
    );

    // flags sit at the same index as their registers, port b is spare
    storage_bank #(.entry_t(logic)) flag_bank_i
    (
        .clock        (clock),
        .arst_n       (arst_n),
        .write_enable (reg_write),
        .write_index  (instr_i.rd),
        .write_data   (alu_flag),
        .read_index_a (instr_i.ra),
        .read_index_b (instr_i.rb),
        .read_a       (flag_a_value),
        .read_b       ()
    );

    // store data is always register ra
    assign datao = reg_a_value;

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

    // machine widths
    localparam int WORD_WIDTH   = 32;
    localparam int BANK_DEPTH   = 8;
    localparam int INDEX_WIDTH  = 3;
    localparam int OPCODE_WIDTH = 6;
    localparam int VALUE_WIDTH  = 16;

    // instruction word layout
    localparam int OPCODE_LSB  = 0;
    localparam int RA_LSB      = 6;
    localparam int RB_LSB      = 9;
    localparam int RD_LSB      = 12;
    localparam int HIGHLOW_BIT = 15;
    localparam int VALUE_LSB   = 16;

    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OPCODE_WIDTH-1:0] opcode_t;

    // one instruction walks through all three phases in order
    typedef enum logic [1:0]
    {
        PHASE_FETCH   = 2'd0,
        PHASE_EXECUTE = 2'd1,
        PHASE_ADVANCE = 2'd2
    } phase_t;

    localparam opcode_t OP_NOP   = 6'd0;
    localparam opcode_t OP_ADD   = 6'd1;
    localparam opcode_t OP_SUB   = 6'd2;
    localparam opcode_t OP_AND   = 6'd3;
    localparam opcode_t OP_OR    = 6'd4;
    localparam opcode_t OP_XOR   = 6'd5;
    localparam opcode_t OP_LDI   = 6'd6;
    localparam opcode_t OP_STORE = 6'd7;
    localparam opcode_t OP_CMPLT = 6'd8;
    // branch if flag ra is set
    localparam opcode_t OP_BRF   = 6'd9;
    localparam opcode_t OP_JMP   = 6'd10;

endpackage

/* source/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer
(
    input  logic           clock,
    input  logic           arst_n,
    input  logic           step,
    input  cpu_pkg::word_t data,
    input  cpu_pkg::word_t store_address,
    input  logic           branch_flag,
    instr_if.sequencer     instr,
    output logic           reg_write,
    output cpu_pkg::word_t address,
    output logic           rw
);

    cpu_pkg::phase_t  phase;
    cpu_pkg::word_t   ir;
    cpu_pkg::word_t   pc;
    cpu_pkg::word_t   pc_next;
    cpu_pkg::opcode_t opcode;
    logic [cpu_pkg::VALUE_WIDTH-1:0] value;
    logic             writes_result;
    logic             is_store;
    logic             take_branch;

    assign opcode = ir[cpu_pkg::OPCODE_LSB +: cpu_pkg::OPCODE_WIDTH];
    assign value  = ir[cpu_pkg::VALUE_LSB +: cpu_pkg::VALUE_WIDTH];

    assign instr.opcode  = opcode;
    assign instr.ra      = ir[cpu_pkg::RA_LSB +: cpu_pkg::INDEX_WIDTH];
    assign instr.rb      = ir[cpu_pkg::RB_LSB +: cpu_pkg::INDEX_WIDTH];
    assign instr.rd      = ir[cpu_pkg::RD_LSB +: cpu_pkg::INDEX_WIDTH];
    assign instr.highlow = ir[cpu_pkg::HIGHLOW_BIT];
    assign instr.value   = value;

    // opcode groups
    assign writes_result = opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
                                          cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                                          cpu_pkg::OP_XOR, cpu_pkg::OP_LDI,
                                          cpu_pkg::OP_CMPLT};
    assign is_store      = opcode == cpu_pkg::OP_STORE;
    // branch_flag is flag ra
    assign take_branch   = (opcode == cpu_pkg::OP_JMP) ||
                           (opcode == cpu_pkg::OP_BRF && branch_flag);

    assign pc_next = take_branch ? cpu_pkg::word_t'(value) : pc + cpu_pkg::word_t'(1);

    // the banks write at the same edge that leaves execute
    assign reg_write = step && phase == cpu_pkg::PHASE_EXECUTE && writes_result;

    always_comb
    begin
        address = pc;
        rw      = 1'b1;
        if (phase == cpu_pkg::PHASE_EXECUTE && is_store)
        begin
            address = store_address;
            rw      = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase <= cpu_pkg::PHASE_FETCH;
            ir    <= '0;
            pc    <= '0;
        end
        else if (step)
        begin
            case (phase)
                cpu_pkg::PHASE_FETCH:
                begin
                    ir    <= data;
                    phase <= cpu_pkg::PHASE_EXECUTE;
                end
                cpu_pkg::PHASE_EXECUTE:
                begin
                    phase <= cpu_pkg::PHASE_ADVANCE;
                end
                default:
                begin
                    pc    <= pc_next;
                    phase <= cpu_pkg::PHASE_FETCH;
                end
            endcase
        end
    end

    // phase only moves on a step
    a_phase_legal: assert property (
        @(posedge clock) disable iff (!arst_n)
        phase inside {cpu_pkg::PHASE_FETCH, cpu_pkg::PHASE_EXECUTE, cpu_pkg::PHASE_ADVANCE}
            && ($stable(phase) || $past(step))
    );

    // a store ends with the step that leaves execute
    a_write_only_in_execute: assert property (
        @(posedge clock) disable iff (!arst_n)
        !rw && step |=> rw && phase == cpu_pkg::PHASE_ADVANCE
    );

    // a register write is the step out of execute
    a_reg_write_in_execute: assert property (
        @(posedge clock) disable iff (!arst_n)
        reg_write |=> phase == cpu_pkg::PHASE_ADVANCE
    );

endmodule

/* source/instr_if.sv */
`timescale 1ns/1ps

interface instr_if;

    cpu_pkg::opcode_t               opcode;
    cpu_pkg::index_t                ra;
    cpu_pkg::index_t                rb;
    cpu_pkg::index_t                rd;
    logic                           highlow;
    logic [cpu_pkg::VALUE_WIDTH-1:0] value;

    // fields come straight out of the instruction register
    modport sequencer
    (
        output opcode,
        output ra,
        output rb,
        output rd,
        output highlow,
        output value
    );

    modport datapath
    (
        input opcode,
        input ra,
        input rb,
        input rd,
        input highlow,
        input value
    );

endinterface

/* source/storage_bank.sv */
`timescale 1ns/1ps

module storage_bank
#(
    parameter type entry_t = cpu_pkg::word_t
)
(
    input  logic            clock,
    input  logic            arst_n,
    input  logic            write_enable,
    input  cpu_pkg::index_t write_index,
    input  entry_t          write_data,
    input  cpu_pkg::index_t read_index_a,
    input  cpu_pkg::index_t read_index_b,
    output entry_t          read_a,
    output entry_t          read_b
);

    entry_t entries [cpu_pkg::BANK_DEPTH];

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < cpu_pkg::BANK_DEPTH; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (write_enable)
        begin
            entries[write_index] <= write_data;
        end
    end

    // both read ports are plain muxes, a write shows up after the edge
    assign read_a = entries[read_index_a];
    assign read_b = entries[read_index_b];

    // the write index comes from the sequencer's instruction register
    a_write_index_known: assert property (
        @(posedge clock) disable iff (!arst_n)
        write_enable |-> !$isunknown(write_index)
    );

endmodule

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// memory size and program shape
localparam int MEM_DEPTH     = 256;
localparam int MEM_ADDR_BITS = 8;
localparam int STORE_BASE    = 'hc0;
localparam int ALU_GROUPS    = 6;
localparam int ALU_PER_GROUP = 4;
localparam int RESET_TIMEOUT = 100;
localparam int HALT_TIMEOUT  = 4000;

typedef logic [cpu_pkg::VALUE_WIDTH-1:0] value_t;

cpu_pkg::word_t prog_image  [MEM_DEPTH];
cpu_pkg::word_t model_mem   [MEM_DEPTH];
cpu_pkg::word_t model_regs  [cpu_pkg::BANK_DEPTH];
logic           model_flags [cpu_pkg::BANK_DEPTH];
cpu_pkg::word_t model_pc;
int             prog_len;

function automatic cpu_pkg::word_t encode(input cpu_pkg::opcode_t op, input cpu_pkg::index_t rd,
                                          input cpu_pkg::index_t ra, input cpu_pkg::index_t rb,
                                          input logic highlow, input value_t value);
    cpu_pkg::word_t w;
    w = '0;
    w[cpu_pkg::OPCODE_LSB +: cpu_pkg::OPCODE_WIDTH] = op;
    w[cpu_pkg::RA_LSB +: cpu_pkg::INDEX_WIDTH]      = ra;
    w[cpu_pkg::RB_LSB +: cpu_pkg::INDEX_WIDTH]      = rb;
    w[cpu_pkg::RD_LSB +: cpu_pkg::INDEX_WIDTH]      = rd;
    w[cpu_pkg::HIGHLOW_BIT]                         = highlow;
    w[cpu_pkg::VALUE_LSB +: cpu_pkg::VALUE_WIDTH]   = value;
    return w;
endfunction

function automatic void emit(input cpu_pkg::word_t w);
    prog_image[prog_len] = w;
    prog_len++;
endfunction

// r7 stays free as the store pointer
function automatic void emit_random_alu();
    cpu_pkg::opcode_t op;
    op = cpu_pkg::opcode_t'(cpu_pkg::OP_ADD + $urandom % 5);
    emit(encode(op, cpu_pkg::index_t'($urandom % 7), cpu_pkg::index_t'($urandom),
                cpu_pkg::index_t'($urandom), 1'b0, '0));
endfunction

function automatic void build_program();
    int              skip;
    cpu_pkg::index_t flag_reg;
    prog_len = 0;
    for (int i = 0; i < MEM_DEPTH; i++)
    begin
        prog_image[i] = 32'h5a00_0000 ^ (cpu_pkg::word_t'(i) * 32'h0001_0101);
    end
    for (int r = 0; r < cpu_pkg::BANK_DEPTH; r++)
    begin
        emit(encode(cpu_pkg::OP_LDI, cpu_pkg::index_t'(r), '0, '0, 1'b0, value_t'($urandom)));
        emit(encode(cpu_pkg::OP_LDI, cpu_pkg::index_t'(r), cpu_pkg::index_t'(r), '0, 1'b1,
                    value_t'($urandom)));
    end
    for (int g = 0; g < ALU_GROUPS; g++)
    begin
        for (int k = 0; k < ALU_PER_GROUP; k++)
        begin
            emit_random_alu();
        end
        flag_reg = cpu_pkg::index_t'($urandom % 7);
        emit(encode(cpu_pkg::OP_CMPLT, flag_reg, cpu_pkg::index_t'($urandom),
                    cpu_pkg::index_t'($urandom), 1'b0, '0));
        // forward branch over the next few instructions
        skip = 1 + int'($urandom % 3);
        emit(encode(cpu_pkg::OP_BRF, '0, flag_reg, '0, 1'b0, value_t'(prog_len + 1 + skip)));
        for (int k = 0; k < skip; k++)
        begin
            emit_random_alu();
        end
    end
    for (int r = 0; r < cpu_pkg::BANK_DEPTH; r++)
    begin
        emit(encode(cpu_pkg::OP_LDI, 3'd7, '0, '0, 1'b0, value_t'(STORE_BASE + r)));
        emit(encode(cpu_pkg::OP_STORE, '0, cpu_pkg::index_t'(r), 3'd7, 1'b0, '0));
    end
    emit(encode(cpu_pkg::OP_JMP, '0, '0, '0, 1'b0, value_t'(prog_len)));
endfunction

function automatic void reset_model();
    for (int i = 0; i < cpu_pkg::BANK_DEPTH; i++)
    begin
        model_regs[i]  = '0;
        model_flags[i] = 1'b0;
    end
    for (int i = 0; i < MEM_DEPTH; i++)
    begin
        model_mem[i] = prog_image[i];
    end
    model_pc = '0;
endfunction

function automatic void model_step(output cpu_pkg::word_t fetch_addr, output logic is_store,
                                   output cpu_pkg::word_t store_addr,
                                   output cpu_pkg::word_t store_data,
                                   output cpu_pkg::word_t next_pc);
    cpu_pkg::word_t   instr;
    cpu_pkg::opcode_t op;
    cpu_pkg::index_t  ra;
    cpu_pkg::index_t  rb;
    cpu_pkg::index_t  rd;
    value_t           value;
    cpu_pkg::word_t   a;
    cpu_pkg::word_t   b;
    cpu_pkg::word_t   res;
    logic             flg;
    logic             writes;
    instr  = model_mem[model_pc[MEM_ADDR_BITS-1:0]];
    op     = instr[cpu_pkg::OPCODE_LSB +: cpu_pkg::OPCODE_WIDTH];
    ra     = instr[cpu_pkg::RA_LSB +: cpu_pkg::INDEX_WIDTH];
    rb     = instr[cpu_pkg::RB_LSB +: cpu_pkg::INDEX_WIDTH];
    rd     = instr[cpu_pkg::RD_LSB +: cpu_pkg::INDEX_WIDTH];
    value  = instr[cpu_pkg::VALUE_LSB +: cpu_pkg::VALUE_WIDTH];
    a      = model_regs[ra];
    b      = model_regs[rb];
    res    = '0;
    flg    = 1'b0;
    writes = 1'b1;
    case (op)
        cpu_pkg::OP_ADD:
        begin
            res = a + b;
            // a carry out leaves the wrapped sum below an operand
            flg = res < a;
        end
        cpu_pkg::OP_SUB:
        begin
            res = a - b;
            flg = a < b;
        end
        cpu_pkg::OP_AND: res = a & b;
        cpu_pkg::OP_OR:  res = a | b;
        cpu_pkg::OP_XOR: res = a ^ b;
        cpu_pkg::OP_LDI:
        begin
            res = instr[cpu_pkg::HIGHLOW_BIT] ? {value, a[cpu_pkg::VALUE_WIDTH-1:0]}
                                              : cpu_pkg::word_t'(value);
        end
        cpu_pkg::OP_CMPLT:
        begin
            flg = a < b;
            res = cpu_pkg::word_t'(flg);
        end
        default: writes = 1'b0;
    endcase
    // logic ops and ldi flag a zero result
    if (op inside {cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_LDI})
    begin
        flg = res == '0;
    end
    if (writes)
    begin
        model_regs[rd]  = res;
        model_flags[rd] = flg;
    end
    is_store   = op == cpu_pkg::OP_STORE;
    store_addr = b;
    store_data = a;
    if (is_store)
    begin
        model_mem[b[MEM_ADDR_BITS-1:0]] = a;
    end
    fetch_addr = model_pc;
    if (op == cpu_pkg::OP_JMP || (op == cpu_pkg::OP_BRF && model_flags[ra]))
    begin
        next_pc = cpu_pkg::word_t'(value);
    end
    else
    begin
        next_pc = model_pc + 1;
    end
    model_pc = next_pc;
endfunction

`endif

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    `include "tb_model.svh"

    logic           clock;
    logic           arst_n;
    logic           step;
    cpu_pkg::word_t data;
    cpu_pkg::word_t datao;
    cpu_pkg::word_t address;
    logic           rw;

    cpu_pkg::word_t mem [MEM_DEPTH];

    // bus values expected for the instruction in flight
    int             phase_count;
    logic           halted;
    cpu_pkg::word_t exp_fetch;
    logic           exp_store;
    cpu_pkg::word_t exp_store_addr;
    cpu_pkg::word_t exp_store_data;
    cpu_pkg::word_t exp_next_pc;

    cpu_core dut_i
    (
        .clock   (clock),
        .arst_n  (arst_n),
        .step    (step),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #20 clock = ~clock;
        end
    end

    // program image loads while reset is held
    assign data = mem[address[MEM_ADDR_BITS-1:0]];

    always @(posedge clock)
    begin
        if (!arst_n)
        begin
            mem <= prog_image;
        end
        else if (!rw)
        begin
            mem[address[MEM_ADDR_BITS-1:0]] <= datao;
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t expected);
        assert (got === expected)
        else
        begin
            stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, expected));
        end
    endtask

    // compares the bus on every rising edge, stepped or not
    initial
    begin
        int waited;
        phase_count = 0;
        halted      = 1'b0;
        waited      = 0;
        do
        begin
            @(posedge clock);
            waited++;
        end
        while (arst_n !== 1'b1 && waited < RESET_TIMEOUT);
        if (arst_n !== 1'b1)
        begin
            stop_on_error("reset was not released within the timeout");
        end
        else
        begin
            reset_model();
            forever
            begin
                if (!halted)
                begin
                    case (phase_count)
                        0:
                        begin
                            check_word("address", address, model_pc);
                            check_word("rw", cpu_pkg::word_t'(rw), 32'h1);
                            if (step)
                            begin
                                model_step(exp_fetch, exp_store, exp_store_addr,
                                           exp_store_data, exp_next_pc);
                                phase_count = 1;
                            end
                        end
                        1:
                        begin
                            if (exp_store)
                            begin
                                check_word("address", address, exp_store_addr);
                                check_word("datao", datao, exp_store_data);
                                check_word("rw", cpu_pkg::word_t'(rw), 32'h0);
                            end
                            else
                            begin
                                check_word("address", address, exp_fetch);
                                check_word("rw", cpu_pkg::word_t'(rw), 32'h1);
                            end
                            if (step)
                            begin
                                phase_count = 2;
                            end
                        end
                        default:
                        begin
                            check_word("address", address, exp_fetch);
                            check_word("rw", cpu_pkg::word_t'(rw), 32'h1);
                            if (step)
                            begin
                                phase_count = 0;
                                // the closing jump targets itself
                                halted = exp_next_pc == exp_fetch;
                            end
                        end
                    endcase
                end
                @(posedge clock);
            end
        end
    end

    initial
    begin
        int cycles;
        void'($urandom(32'hd572));
        arst_n = 1'b0;
        step   = 1'b0;
        build_program();
        repeat (10)
        begin
            @(negedge clock);
        end
        arst_n = 1'b1;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT)
        begin
            @(negedge clock);
            step = ($urandom % 4) != 0;
            cycles++;
        end
        if (!halted)
        begin
            stop_on_error("program did not reach its halt loop within the timeout");
        end
        else
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
            begin
                check_word($sformatf("mem[%0d]", i), mem[i], model_mem[i]);
            end
            $display("Simulation passed");
            $finish;
        end
    end

endmodule
